/* sprite_engine.f */
+incdir+design
design/axil_pkg.sv
design/sprite_pkg.sv
design/sprite_memory.sv
design/sprite_line_scanner.sv
design/sprite_hit_fifo.sv
design/sprite_line_drawer.sv
design/sprite_line_buffer.sv
design/sprite_engine_top.sv
bench/sprite_engine_tb.sv

/* bench/sprite_engine_tb.sv */
// Sprite engine testbench
`timescale 1ns/1ps
`include "sprite_defs.svh"

module sprite_engine_tb;

	// Roughly 40 lines of 300 cycles plus bus traffic and margin
	localparam int TIMEOUT_CYCLES = 20000;
	// Minimum line period
	localparam int LINE_CYCLES    = 300;

	logic                CLK_12M = 1'b0;
	logic                RST_4L;
	axil_pkg::axil_req_t axil_req;
	axil_pkg::axil_rsp_t axil_rsp;
	logic                line_start;
	logic [7:0]          line_y;
	sprite_pkg::pixel_t  pix;
	logic                pix_valid;

	// Host-side copies of the tables
	sprite_pkg::sprite_attr_t attr_mirror [`SPR_COUNT];
	logic [31:0]              pat_mirror [`PAT_COUNT * `SPR_SIZE];

	// Captured and predicted lines
	logic [3:0] got_line [`LINE_WIDTH];
	logic [3:0] exp_line [`LINE_WIDTH];

	int          error_count = 0;
	int          check_count = 0;
	int          cycle_count = 0;
	int unsigned seed_val    = 32'ha1f0602f;

	sprite_engine_top sprite_engine_top_i
	(
		.CLK_12M    (CLK_12M),
		.RST_4L     (RST_4L),
		.axil_req   (axil_req),
		.axil_rsp   (axil_rsp),
		.line_start (line_start),
		.line_y     (line_y),
		.pix        (pix),
		.pix_valid  (pix_valid)
	);

	// 8 ns period
	always #4 CLK_12M = ~CLK_12M;

	// Watchdog
	always @(posedge CLK_12M)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic check_val(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		if (got !== expected)
		begin
			error_count++;
			$display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	//------------------------------------------------------------
	// AXI4-Lite master
	//------------------------------------------------------------
	task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output axil_pkg::axil_resp_e resp);
		@(negedge CLK_12M);
		axil_req.awaddr  = addr;
		axil_req.wdata   = data;
		axil_req.wstrb   = strb;
		axil_req.awvalid = 1'b1;
		axil_req.wvalid  = 1'b1;
		axil_req.bready  = 1'b1;
		// Address and data held through the accept cycle
		@(negedge CLK_12M);
		while (!axil_rsp.awready)
			@(negedge CLK_12M);
		// Both channels accepted in the same cycle
		check_val("wready with awready", 32'(axil_rsp.wready), 32'd1);
		@(negedge CLK_12M);
		while (!axil_rsp.bvalid)
			@(negedge CLK_12M);
		resp             = axil_rsp.bresp;
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		@(negedge CLK_12M);
		axil_req.bready  = 1'b0;
	endtask

	task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
		output axil_pkg::axil_resp_e resp);
		@(negedge CLK_12M);
		axil_req.araddr  = addr;
		axil_req.arvalid = 1'b1;
		axil_req.rready  = 1'b1;
		@(negedge CLK_12M);
		while (!axil_rsp.arready)
			@(negedge CLK_12M);
		@(negedge CLK_12M);
		while (!axil_rsp.rvalid)
			@(negedge CLK_12M);
		data             = axil_rsp.rdata;
		resp             = axil_rsp.rresp;
		axil_req.arvalid = 1'b0;
		@(negedge CLK_12M);
		axil_req.rready  = 1'b0;
	endtask

	//------------------------------------------------------------
	// Table setup
	//------------------------------------------------------------
	task automatic set_sprite(input int index, input logic [7:0] x, input logic [7:0] y,
		input logic [5:0] pattern, input logic [1:0] palette,
		input logic hflip, input logic vflip);
		sprite_pkg::sprite_attr_t a;
		axil_pkg::axil_resp_e     resp;
		a.enable  = 1'b1;
		a.vflip   = vflip;
		a.hflip   = hflip;
		a.palette = palette;
		a.pattern = pattern;
		a.y       = y;
		a.x       = x;
		attr_mirror[index] = a;
		axil_write(32'(index * 4), {5'h0, a}, 4'hF, resp);
		check_val("attribute write response", 32'(resp), 32'(axil_pkg::RESP_OKAY));
	endtask

	task automatic clear_sprites();
		axil_pkg::axil_resp_e resp;
		for (int i = 0; i < `SPR_COUNT; i++)
		begin
			attr_mirror[i] = '0;
			axil_write(32'(i * 4), 32'h0, 4'hF, resp);
		end
	endtask

	// Random rows for one pattern
	task automatic load_pattern(input int p);
		axil_pkg::axil_resp_e resp;
		logic [31:0]          w;
		for (int row = 0; row < `SPR_SIZE; row++)
		begin
			w = $urandom;
			pat_mirror[p * `SPR_SIZE + row] = w;
			axil_write(`ADDR_PAT_BASE + 32'((p * `SPR_SIZE + row) * 4), w, 4'hF, resp);
			check_val("pattern write response", 32'(resp), 32'(axil_pkg::RESP_OKAY));
		end
	endtask

	//------------------------------------------------------------
	// Line stimulus, capture and model
	//------------------------------------------------------------
	// Output must start the cycle after the pulse and last 256 cycles
	task automatic capture_line();
		int valid_count;
		valid_count = 0;
		check_val("pix_valid after line_start", 32'(pix_valid), 32'd1);
		for (int x = 0; x < `LINE_WIDTH; x++)
		begin
			got_line[x] = pix;
			if (pix_valid)
				valid_count++;
			@(negedge CLK_12M);
		end
		check_val("cycles with pix_valid", 32'(valid_count), 32'(`LINE_WIDTH));
		check_val("pix_valid after last pixel", 32'(pix_valid), 32'd0);
	endtask

	// Pulse line_start, capture the previous line, pad to the line period
	task automatic run_line(input logic [7:0] y);
		@(negedge CLK_12M);
		line_start = 1'b1;
		line_y     = y;
		@(negedge CLK_12M);
		line_start = 1'b0;
		capture_line();
		repeat (LINE_CYCLES - `LINE_WIDTH) @(negedge CLK_12M);
	endtask

	// Paints the expected line from the mirrors
	task automatic build_expected(input logic [7:0] y, output int hit_total);
		sprite_pkg::sprite_attr_t a;
		logic [7:0]               diff;
		logic [3:0]               row;
		logic [31:0]              word;
		logic [1:0]               idx;
		int                       px;
		hit_total = 0;
		for (int x = 0; x < `LINE_WIDTH; x++)
			exp_line[x] = 4'h0;
		for (int s = 0; s < `SPR_COUNT; s++)
		begin
			a    = attr_mirror[s];
			diff = y - a.y;
			if (a.enable && diff < 8'd16)
			begin
				hit_total++;
				// Hits past the per-line limit draw nothing
				if (hit_total <= `MAX_PER_LINE)
				begin
					row  = a.vflip ? 4'd15 - diff[3:0] : diff[3:0];
					word = pat_mirror[a.pattern * 16 + row];
					for (int i = 0; i < 16; i++)
					begin
						idx = word[2 * i +: 2];
						px  = a.hflip ? int'(a.x) + 15 - i : int'(a.x) + i;
						// Earlier sprite keeps its pixel
						if (idx != 2'd0 && px < `LINE_WIDTH && exp_line[px] == 4'h0)
							exp_line[px] = {a.palette, idx};
					end
				end
			end
		end
	endtask

	task automatic compare_line(input logic [7:0] y);
		for (int x = 0; x < `LINE_WIDTH; x++)
			check_val($sformatf("line %0d pixel %0d", y, x), 32'(got_line[x]),
				32'(exp_line[x]));
	endtask

	// Draw a line, then show it on the next one
	task automatic show_line(input logic [7:0] y);
		int hits;
		run_line(y);
		run_line(y);
		build_expected(y, hits);
		compare_line(y);
	endtask

	task automatic expect_blank(input logic [7:0] y);
		for (int x = 0; x < `LINE_WIDTH; x++)
			exp_line[x] = 4'h0;
		compare_line(y);
	endtask

	//------------------------------------------------------------
	// Directed tests
	//------------------------------------------------------------
	task automatic test_reset_state();
		check_val("pix_valid after reset", 32'(pix_valid), 32'd0);
		check_val("bvalid after reset", 32'(axil_rsp.bvalid), 32'd0);
		check_val("rvalid after reset", 32'(axil_rsp.rvalid), 32'd0);
		// Both halves come out blank
		run_line(8'd0);
		expect_blank(8'd0);
		run_line(8'd0);
		expect_blank(8'd0);
	endtask

	task automatic test_register_access();
		axil_pkg::axil_resp_e resp;
		logic [31:0]          data;
		axil_read(`ADDR_STATUS, data, resp);
		check_val("status after reset", data, 32'h0);
		axil_write(32'h00C, 32'h05A3_C3B7, 4'hF, resp);
		check_val("attribute write response", 32'(resp), 32'(axil_pkg::RESP_OKAY));
		axil_read(32'h00C, data, resp);
		check_val("attribute read back", data, 32'h05A3_C3B7);
		check_val("attribute read response", 32'(resp), 32'(axil_pkg::RESP_OKAY));
		axil_write(32'h1FFC, 32'hDEAD_BEEF, 4'hF, resp);
		pat_mirror[1023] = 32'hDEAD_BEEF;
		axil_read(32'h1FFC, data, resp);
		check_val("pattern read back", data, 32'hDEAD_BEEF);
		// Partial strobe refused, word unchanged
		axil_write(32'h00C, 32'h0000_0000, 4'h3, resp);
		check_val("partial strobe response", 32'(resp), 32'(axil_pkg::RESP_SLVERR));
		axil_read(32'h00C, data, resp);
		check_val("attribute after refused write", data, 32'h05A3_C3B7);
		axil_write(32'h0800, 32'h1234_5678, 4'hF, resp);
		check_val("unmapped write response", 32'(resp), 32'(axil_pkg::RESP_SLVERR));
		axil_read(32'h2000, data, resp);
		check_val("unmapped read response", 32'(resp), 32'(axil_pkg::RESP_SLVERR));
		check_val("unmapped read data", data, 32'h0);
	endtask

	task automatic test_single_sprite();
		clear_sprites();
		set_sprite(2, 8'd40, 8'd60, 6'd1, 2'd2, 1'b0, 1'b0);
		show_line(8'd67);
	endtask

	task automatic test_flips();
		clear_sprites();
		set_sprite(4, 8'd100, 8'd30, 6'd2, 2'd1, 1'b1, 1'b0);
		show_line(8'd33);
		set_sprite(4, 8'd100, 8'd30, 6'd2, 2'd1, 1'b0, 1'b1);
		show_line(8'd33);
	endtask

	task automatic test_overlap();
		clear_sprites();
		set_sprite(1, 8'd50, 8'd90, 6'd3, 2'd3, 1'b0, 1'b0);
		set_sprite(6, 8'd58, 8'd85, 6'd1, 2'd1, 1'b0, 1'b0);
		show_line(8'd95);
	endtask

	task automatic test_clip_and_limit();
		axil_pkg::axil_resp_e resp;
		logic [31:0]          data;
		int                   hits;
		clear_sprites();
		set_sprite(0, 8'd248, 8'd10, 6'd2, 2'd1, 1'b0, 1'b0);
		show_line(8'd12);
		// Ten sprites side by side on line 210
		clear_sprites();
		axil_write(`ADDR_STATUS, 32'h0, 4'hF, resp);
		for (int s = 0; s < 10; s++)
			set_sprite(s, 8'(s * 24), 8'(200 + s), 6'(1 + s % 3), 2'(s % 4), s[0], 1'b0);
		show_line(8'd210);
		build_expected(8'd210, hits);
		axil_read(`ADDR_STATUS, data, resp);
		check_val("overflow bit", data, (hits > `MAX_PER_LINE) ? 32'd1 : 32'd0);
		axil_write(`ADDR_STATUS, 32'h0, 4'hF, resp);
		axil_read(`ADDR_STATUS, data, resp);
		check_val("overflow bit after clear", data, 32'h0);
	endtask

	task automatic test_clear_on_read();
		int hits;
		clear_sprites();
		set_sprite(5, 8'd120, 8'd140, 6'd3, 2'd2, 1'b1, 1'b1);
		run_line(8'd145);
		run_line(8'd0);
		build_expected(8'd145, hits);
		compare_line(8'd145);
		// Each half must come back empty
		run_line(8'd0);
		expect_blank(8'd0);
		run_line(8'd0);
		expect_blank(8'd0);
	endtask

	initial
	begin
		seed_val   = $urandom(seed_val);
		RST_4L     = 1'b0;
		axil_req   = '0;
		line_start = 1'b0;
		line_y     = 8'd0;
		for (int i = 0; i < `SPR_COUNT; i++)
			attr_mirror[i] = '0;
		repeat (8) @(negedge CLK_12M);
		RST_4L = 1'b1;
		@(negedge CLK_12M);

		test_reset_state();
		test_register_access();
		load_pattern(1);
		load_pattern(2);
		load_pattern(3);
		test_single_sprite();
		test_flips();
		test_overlap();
		test_clip_and_limit();
		test_clear_on_read();

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* design/sprite_engine_top.sv */
// Sprite line engine top
`timescale 1ns/1ps

module sprite_engine_top
(
	input  logic                CLK_12M,
	input  logic                RST_4L,
	input  axil_pkg::axil_req_t axil_req,
	output axil_pkg::axil_rsp_t axil_rsp,
	input  logic                line_start,
	input  logic [7:0]          line_y,
	output sprite_pkg::pixel_t  pix,
	output logic                pix_valid
);

	// Memory side
	logic [3:0]               attr_index;
	sprite_pkg::sprite_attr_t attr;
	logic [9:0]               pat_row_index;
	logic [31:0]              pat_row;
	logic                     overflow_set;

	// Scanner to FIFO to drawer
	sprite_pkg::sprite_hit_t  scan_hit;
	logic                     scan_valid;
	logic                     scan_ready;
	sprite_pkg::sprite_hit_t  draw_hit;
	logic                     draw_valid;
	logic                     draw_ready;

	// Drawer to line buffer
	logic                     wr_en;
	logic [7:0]               wr_x;
	sprite_pkg::pixel_t       wr_pix;
	sprite_pkg::pixel_t       cur_pix;

	sprite_memory sprite_memory_i
	(
		.CLK_12M       (CLK_12M),
		.RST_4L        (RST_4L),
		.axil_req      (axil_req),
		.axil_rsp      (axil_rsp),
		.attr_index    (attr_index),
		.attr          (attr),
		.pat_row_index (pat_row_index),
		.pat_row       (pat_row),
		.overflow_set  (overflow_set)
	);

	sprite_line_scanner sprite_line_scanner_i
	(
		.CLK_12M      (CLK_12M),
		.RST_4L       (RST_4L),
		.line_start   (line_start),
		.line_y       (line_y),
		.attr_index   (attr_index),
		.attr         (attr),
		.hit          (scan_hit),
		.hit_valid    (scan_valid),
		.hit_ready    (scan_ready),
		.overflow_set (overflow_set)
	);

	sprite_hit_fifo sprite_hit_fifo_i
	(
		.CLK_12M    (CLK_12M),
		.RST_4L     (RST_4L),
		.line_start (line_start),
		.in_hit     (scan_hit),
		.in_valid   (scan_valid),
		.in_ready   (scan_ready),
		.out_hit    (draw_hit),
		.out_valid  (draw_valid),
		.out_ready  (draw_ready)
	);

	sprite_line_drawer sprite_line_drawer_i
	(
		.CLK_12M       (CLK_12M),
		.RST_4L        (RST_4L),
		.hit           (draw_hit),
		.hit_valid     (draw_valid),
		.hit_ready     (draw_ready),
		.pat_row_index (pat_row_index),
		.pat_row       (pat_row),
		.wr_en         (wr_en),
		.wr_x          (wr_x),
		.wr_pix        (wr_pix),
		.cur_pix       (cur_pix)
	);

	sprite_line_buffer sprite_line_buffer_i
	(
		.CLK_12M    (CLK_12M),
		.RST_4L     (RST_4L),
		.line_start (line_start),
		.wr_en      (wr_en),
		.wr_x       (wr_x),
		.wr_pix     (wr_pix),
		.cur_pix    (cur_pix),
		.pix        (pix),
		.pix_valid  (pix_valid)
	);

endmodule

/* design/sprite_line_buffer.sv */
// Double line buffer
`timescale 1ns/1ps
`include "sprite_defs.svh"

module sprite_line_buffer
(
	input  logic               CLK_12M,
	input  logic               RST_4L,
	input  logic               line_start,
	input  logic               wr_en,
	input  logic [7:0]         wr_x,
	input  sprite_pkg::pixel_t wr_pix,
	output sprite_pkg::pixel_t cur_pix,
	output sprite_pkg::pixel_t pix,
	output logic               pix_valid
);

	sprite_pkg::pixel_t buf_q [2][`LINE_WIDTH];
	// Half being drawn, the other one is on display
	logic               sel_q;
	logic               active_q;
	logic [7:0]         rd_x_q;

	// Draw side lookup for the transparency test
	assign cur_pix   = buf_q[sel_q][wr_x];
	assign pix       = buf_q[~sel_q][rd_x_q];
	assign pix_valid = active_q;

	always_ff @(posedge CLK_12M or negedge RST_4L)
	begin
		if (!RST_4L)
		begin
			sel_q    <= 1'b0;
			active_q <= 1'b0;
			rd_x_q   <= '0;
			for (int h = 0; h < 2; h++)
				for (int i = 0; i < `LINE_WIDTH; i++)
					buf_q[h][i] <= '0;
		end
		else
		begin
			//------------------------------------------------------------
			// Swap and stream out
			//------------------------------------------------------------
			if (line_start)
			begin
				sel_q    <= ~sel_q;
				active_q <= 1'b1;
				rd_x_q   <= '0;
			end
			else if (active_q)
			begin
				// Clear behind the read so the half is blank for drawing
				buf_q[~sel_q][rd_x_q] <= '0;
				rd_x_q <= rd_x_q + 8'd1;
				if (rd_x_q == 8'(`LINE_WIDTH - 1))
					active_q <= 1'b0;
			end
			if (wr_en)
				buf_q[sel_q][wr_x] <= wr_pix;
		end
	end

endmodule

/* design/sprite_line_drawer.sv */
// Sprite line drawer
`timescale 1ns/1ps
`include "sprite_defs.svh"

module sprite_line_drawer
(
	input  logic                    CLK_12M,
	input  logic                    RST_4L,
	input  sprite_pkg::sprite_hit_t hit,
	input  logic                    hit_valid,
	output logic                    hit_ready,
	output logic [9:0]              pat_row_index,
	input  logic [31:0]             pat_row,
	output logic                    wr_en,
	output logic [7:0]              wr_x,
	output sprite_pkg::pixel_t      wr_pix,
	input  sprite_pkg::pixel_t      cur_pix
);

	sprite_pkg::draw_state_e state_q;
	sprite_pkg::sprite_hit_t hit_q;
	logic [3:0]              cnt_q;
	logic [3:0]              col;
	logic [8:0]              x_sum;
	logic [1:0]              pix_idx;
	logic                    painting;
	logic                    last_paint;

	assign painting   = state_q == sprite_pkg::DRAW_PAINT;
	assign last_paint = painting && (cnt_q == 4'(`SPR_SIZE - 1));
	// Next hit taken on the last paint cycle, no idle gap
	assign hit_ready  = (state_q == sprite_pkg::DRAW_IDLE) || last_paint;

	// Row word for the current hit
	assign pat_row_index = {hit_q.pattern, hit_q.row};

	//------------------------------------------------------------
	// Pixel placement
	//------------------------------------------------------------
	// Mirrored column under hflip
	assign col     = hit_q.hflip ? 4'(`SPR_SIZE - 1) - cnt_q : cnt_q;
	// Ninth bit marks a pixel past the right edge
	assign x_sum   = {1'b0, hit_q.x} + {5'h0, col};
	assign pix_idx = pat_row[{cnt_q, 1'b0} +: 2];

	assign wr_x           = x_sum[7:0];
	assign wr_pix.palette = hit_q.palette;
	assign wr_pix.index   = pix_idx;
	// Earlier (lower index) pixel already there wins
	assign wr_en = painting && (pix_idx != 2'd0) && !x_sum[8] && (cur_pix == '0);

	always_ff @(posedge CLK_12M or negedge RST_4L)
	begin
		if (!RST_4L)
		begin
			state_q <= sprite_pkg::DRAW_IDLE;
			cnt_q   <= '0;
		end
		else
		begin
			case (state_q)
				sprite_pkg::DRAW_IDLE:
				begin
					if (hit_valid)
						state_q <= sprite_pkg::DRAW_FETCH;
				end
				sprite_pkg::DRAW_FETCH:
				begin
					// Row word arrives at this edge
					state_q <= sprite_pkg::DRAW_PAINT;
					cnt_q   <= '0;
				end
				sprite_pkg::DRAW_PAINT:
				begin
					cnt_q <= cnt_q + 4'd1;
					if (last_paint)
						state_q <= hit_valid ? sprite_pkg::DRAW_FETCH : sprite_pkg::DRAW_IDLE;
				end
				default:
					state_q <= sprite_pkg::DRAW_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK_12M)
	begin
		if (hit_valid && hit_ready)
			hit_q <= hit;
	end

endmodule

/* design/sprite_hit_fifo.sv */
// Hit record FIFO
`timescale 1ns/1ps
`include "sprite_defs.svh"

module sprite_hit_fifo
(
	input  logic                    CLK_12M,
	input  logic                    RST_4L,
	input  logic                    line_start,
	input  sprite_pkg::sprite_hit_t in_hit,
	input  logic                    in_valid,
	output logic                    in_ready,
	output sprite_pkg::sprite_hit_t out_hit,
	output logic                    out_valid,
	input  logic                    out_ready
);

	sprite_pkg::sprite_hit_t mem_q [`FIFO_DEPTH];
	logic [2:0]              wr_ptr_q;
	logic [2:0]              rd_ptr_q;
	logic [3:0]              count_q;
	logic                    push;
	logic                    pop;

	assign in_ready  = count_q != 4'(`FIFO_DEPTH);
	assign out_valid = count_q != 4'd0;
	// Head comes straight from the storage registers
	assign out_hit   = mem_q[rd_ptr_q];
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	always_ff @(posedge CLK_12M or negedge RST_4L)
	begin
		if (!RST_4L)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else if (line_start)
		begin
			// Stale hits dropped at each new line
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr_q <= wr_ptr_q + 3'd1;
			if (pop)
				rd_ptr_q <= rd_ptr_q + 3'd1;
			if (push && !pop)
				count_q <= count_q + 4'd1;
			else if (pop && !push)
				count_q <= count_q - 4'd1;
		end
	end

	always_ff @(posedge CLK_12M)
	begin
		if (push && !line_start)
			mem_q[wr_ptr_q] <= in_hit;
	end

	// Producer waits on a full queue with its record held
	full_hold: assert property (@(posedge CLK_12M) disable iff (!RST_4L || line_start)
		in_valid && !in_ready |=> in_valid && $stable(in_hit));

endmodule

/* design/sprite_line_scanner.sv */
// Sprite line scanner
`timescale 1ns/1ps
`include "sprite_defs.svh"

module sprite_line_scanner
(
	input  logic                     CLK_12M,
	input  logic                     RST_4L,
	input  logic                     line_start,
	input  logic [7:0]               line_y,
	output logic [3:0]               attr_index,
	input  sprite_pkg::sprite_attr_t attr,
	output sprite_pkg::sprite_hit_t  hit,
	output logic                     hit_valid,
	input  logic                     hit_ready,
	output logic                     overflow_set
);

	sprite_pkg::scan_state_e state_q;
	logic [7:0]              line_q;
	logic [3:0]              idx_q;
	logic [3:0]              hit_cnt_q;
	logic [7:0]              row_raw;
	logic [3:0]              row;
	logic                    is_hit;
	logic                    stall;
	logic                    step;

	assign attr_index = idx_q;
	// Line minus top edge wraps modulo 256
	assign row_raw = line_q - attr.y;
	assign is_hit  = attr.enable && (row_raw < 8'(`SPR_SIZE));
	assign row     = attr.vflip ? 4'(`SPR_SIZE - 1) - row_raw[3:0] : row_raw[3:0];
	// Full FIFO holds the index
	assign stall   = hit_valid && !hit_ready;
	assign step    = (state_q == sprite_pkg::SCAN_TEST) && !stall && !line_start;

	always_ff @(posedge CLK_12M or negedge RST_4L)
	begin
		if (!RST_4L)
		begin
			state_q      <= sprite_pkg::SCAN_IDLE;
			line_q       <= '0;
			idx_q        <= '0;
			hit_cnt_q    <= '0;
			hit_valid    <= 1'b0;
			overflow_set <= 1'b0;
		end
		else
		begin
			overflow_set <= 1'b0;
			if (hit_valid && hit_ready)
				hit_valid <= 1'b0;
			if (line_start)
			begin
				state_q   <= sprite_pkg::SCAN_TEST;
				line_q    <= line_y;
				idx_q     <= '0;
				hit_cnt_q <= '0;
				hit_valid <= 1'b0;
			end
			else if (step)
			begin
				// Ninth and later hits only flag overflow
				if (is_hit && (hit_cnt_q < 4'(`MAX_PER_LINE)))
				begin
					hit_valid <= 1'b1;
					hit_cnt_q <= hit_cnt_q + 4'd1;
				end
				else if (is_hit)
					overflow_set <= 1'b1;
				idx_q <= idx_q + 4'd1;
				if (idx_q == 4'(`SPR_COUNT - 1))
					state_q <= sprite_pkg::SCAN_IDLE;
			end
		end
	end

	// Hit record
	always_ff @(posedge CLK_12M)
	begin
		if (step && is_hit)
		begin
			hit.x       <= attr.x;
			hit.pattern <= attr.pattern;
			hit.row     <= row;
			hit.palette <= attr.palette;
			hit.hflip   <= attr.hflip;
		end
	end

	// A new line only once the last scan has finished
	no_restart: assert property (@(posedge CLK_12M) disable iff (!RST_4L)
		line_start |-> (state_q != sprite_pkg::SCAN_TEST));

endmodule

/* design/sprite_memory.sv */
// Sprite attribute and pattern memory
`timescale 1ns/1ps
`include "sprite_defs.svh"

module sprite_memory
(
	input  logic                     CLK_12M,
	input  logic                     RST_4L,
	input  axil_pkg::axil_req_t      axil_req,
	output axil_pkg::axil_rsp_t      axil_rsp,
	input  logic [3:0]               attr_index,
	output sprite_pkg::sprite_attr_t attr,
	input  logic [9:0]               pat_row_index,
	output logic [31:0]              pat_row,
	input  logic                     overflow_set
);

	sprite_pkg::sprite_attr_t attr_q [`SPR_COUNT];
	logic [31:0]              pat_mem [`PAT_COUNT * `SPR_SIZE];
	logic                     overflow_q;

	// Bus handshake state
	logic                     wr_acc_q;
	logic                     bvalid_q;
	axil_pkg::axil_resp_e     bresp_q;
	logic                     arready_q;
	logic                     rvalid_q;
	axil_pkg::axil_resp_e     rresp_q;
	logic [31:0]              rdata_q;

	// Address decode
	logic                     aw_attr;
	logic                     aw_stat;
	logic                     aw_pat;
	logic                     wr_ok;
	logic                     ar_attr;
	logic                     ar_stat;
	logic                     ar_pat;
	logic [31:0]              rd_word;

	//------------------------------------------------------------
	// Decode of both address channels
	//------------------------------------------------------------
	assign aw_attr = (axil_req.awaddr & 32'hFFFF_FFC0) == 32'h0;
	assign aw_stat = (axil_req.awaddr & 32'hFFFF_FFFC) == `ADDR_STATUS;
	assign aw_pat  = (axil_req.awaddr & 32'hFFFF_F000) == `ADDR_PAT_BASE;
	// Full-word writes only
	assign wr_ok   = (aw_attr || aw_stat || aw_pat) && (axil_req.wstrb == 4'hF);

	assign ar_attr = (axil_req.araddr & 32'hFFFF_FFC0) == 32'h0;
	assign ar_stat = (axil_req.araddr & 32'hFFFF_FFFC) == `ADDR_STATUS;
	assign ar_pat  = (axil_req.araddr & 32'hFFFF_F000) == `ADDR_PAT_BASE;

	// Read mux, unmapped reads as zero
	always_comb
	begin
		rd_word = 32'h0;
		if (ar_attr)
			rd_word = {5'h0, attr_q[axil_req.araddr[5:2]]};
		else if (ar_stat)
			rd_word = {31'h0, overflow_q};
		else if (ar_pat)
			rd_word = pat_mem[axil_req.araddr[11:2]];
	end

	//------------------------------------------------------------
	// Handshakes, attribute table and status flag
	//------------------------------------------------------------
	always_ff @(posedge CLK_12M or negedge RST_4L)
	begin
		if (!RST_4L)
		begin
			wr_acc_q   <= 1'b0;
			bvalid_q   <= 1'b0;
			bresp_q    <= axil_pkg::RESP_OKAY;
			arready_q  <= 1'b0;
			rvalid_q   <= 1'b0;
			rresp_q    <= axil_pkg::RESP_OKAY;
			overflow_q <= 1'b0;
			for (int i = 0; i < `SPR_COUNT; i++)
				attr_q[i] <= '0;
		end
		else
		begin
			// One-cycle accept once both channels are valid
			wr_acc_q <= axil_req.awvalid && axil_req.wvalid && !wr_acc_q && !bvalid_q;
			if (wr_acc_q)
			begin
				bvalid_q <= 1'b1;
				bresp_q  <= wr_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
			end
			else if (axil_req.bready)
				bvalid_q <= 1'b0;

			// Read accept blocked while a response waits
			arready_q <= axil_req.arvalid && !arready_q && !rvalid_q;
			if (arready_q)
			begin
				rvalid_q <= 1'b1;
				rresp_q  <= (ar_attr || ar_stat || ar_pat) ?
					axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
			end
			else if (axil_req.rready)
				rvalid_q <= 1'b0;

			if (wr_acc_q && wr_ok && aw_attr)
				attr_q[axil_req.awaddr[5:2]] <=
					sprite_pkg::sprite_attr_t'(axil_req.wdata[26:0]);
			// Status write clears, a new overflow in the same cycle wins
			if (wr_acc_q && wr_ok && aw_stat)
				overflow_q <= 1'b0;
			if (overflow_set)
				overflow_q <= 1'b1;
		end
	end

	// Pattern RAM, drawer port registered
	always_ff @(posedge CLK_12M)
	begin
		if (wr_acc_q && wr_ok && aw_pat)
			pat_mem[axil_req.awaddr[11:2]] <= axil_req.wdata;
		if (arready_q)
			rdata_q <= rd_word;
		pat_row <= pat_mem[pat_row_index];
	end

	assign attr             = attr_q[attr_index];
	assign axil_rsp.awready = wr_acc_q;
	assign axil_rsp.wready  = wr_acc_q;
	assign axil_rsp.bresp   = bresp_q;
	assign axil_rsp.bvalid  = bvalid_q;
	assign axil_rsp.arready = arready_q;
	assign axil_rsp.rdata   = rdata_q;
	assign axil_rsp.rresp   = rresp_q;
	assign axil_rsp.rvalid  = rvalid_q;

	// Responses wait for the master
	bvalid_hold: assert property (@(posedge CLK_12M) disable iff (!RST_4L)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid);
	rvalid_hold: assert property (@(posedge CLK_12M) disable iff (!RST_4L)
		axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid);

endmodule

/* design/sprite_pkg.sv */
// Sprite engine types
package sprite_pkg;

	// One attribute word, x in bits 7:0 up to enable in bit 26
	typedef struct packed
	{
		logic       enable;
		logic       vflip;
		logic       hflip;
		logic [1:0] palette;
		logic [5:0] pattern;
		logic [7:0] y;
		logic [7:0] x;
	} sprite_attr_t;

	// Queued hit, row already vertically flipped
	typedef struct packed
	{
		logic [7:0] x;
		logic [5:0] pattern;
		logic [3:0] row;
		logic [1:0] palette;
		logic       hflip;
	} sprite_hit_t;

	// Colour of one pixel, all zero is transparent
	typedef struct packed
	{
		logic [1:0] palette;
		logic [1:0] index;
	} pixel_t;

	// Scanner FSM
	typedef enum logic
	{
		SCAN_IDLE,
		SCAN_TEST
	} scan_state_e;

	// Drawer FSM
	typedef enum logic [1:0]
	{
		DRAW_IDLE,
		DRAW_FETCH,
		DRAW_PAINT
	} draw_state_e;

endpackage

/* design/axil_pkg.sv */
// AXI4-Lite bus types
package axil_pkg;

	// Response codes on bresp and rresp
	typedef enum logic [1:0]
	{
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axil_resp_e;

	// Master to slave
	typedef struct packed
	{
		logic [31:0] awaddr;
		logic        awvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        wvalid;
		logic        bready;
		logic [31:0] araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t;

	// Slave to master
	typedef struct packed
	{
		logic        awready;
		logic        wready;
		axil_resp_e  bresp;
		logic        bvalid;
		logic        arready;
		logic [31:0] rdata;
		axil_resp_e  rresp;
		logic        rvalid;
	} axil_rsp_t;

endpackage

/* design/sprite_defs.svh */
// Sprite engine sizes and addresses
`ifndef SPRITE_DEFS_SVH
`define SPRITE_DEFS_SVH

// Object table and pattern geometry
`define SPR_COUNT     16
`define SPR_SIZE      16
`define PAT_COUNT     64

// Line geometry and per-line limits
`define LINE_WIDTH    256
`define MAX_PER_LINE  8
`define FIFO_DEPTH    8

// Host map, byte addresses
`define ADDR_STATUS   32'h0000_0040
`define ADDR_PAT_BASE 32'h0000_1000

`endif
